// ==== files.f ====
+incdir+hw
hw/neo_bridge_pkg.sv
hw/span_mask.sv
hw/rom_mask_tracker.sv
hw/core_option_regs.sv
hw/pad_layout_remap.sv
hw/neo_bridge_top.sv
verif/neo_bridge_checker.sv
verif/tb_neo_bridge.sv

// ==== hw/core_option_regs.sv ====
////////////////////////////////////////
// core_option_regs
// option registers, pchip encoding and
// the core start gate
////////////////////////////////////////

`timescale 1ns/1ps
`include "neo_bridge_config.svh"

module core_option_regs (
	input logic clk_sys,
	input logic reset_l_main,
	input neo_bridge_pkg::bridge_req_t bridge,
	input logic dataslot_allcomplete,
	input logic core_run,
	input neo_bridge_pkg::pad_keys_t p1_keys,
	output neo_bridge_pkg::core_options_t options,
	output neo_bridge_pkg::pad_layout_e pad_layout [`NB_PLAYERS],
	output logic [`NB_DATA_W-1:0] bridge_rd_data,
	output logic start_system
);

	import neo_bridge_pkg::*;

	localparam int DW = `NB_DATA_W;
	localparam int OFF_W = $clog2(`NB_OPT_LAST + 1);
	localparam logic [`NB_ADDR_W-1:0] OPT_BASE = `NB_OPT_BASE;

	typedef logic [OFF_W-1:0] off_t;

	off_t offset;
	logic in_map;
	logic pchip_main;
	logic [2:0] pchip_sub;
	logic [DW-1:0] rd_mux;

	// main chip wins, sub chips 1 to 5 map to 3 to 7
	function automatic logic [3:0] pchip_encode(input logic main, input logic [2:0] sub);
		logic [3:0] code;
		code = 4'd0;
		if (main) begin
			code = 4'd2;
		end else if (sub >= 3'd1 && sub <= 3'd5) begin
			code = 4'(sub) + 4'd2;
		end
		return code;
	endfunction

	assign offset = bridge.addr[OFF_W-1:0];
	assign in_map = (bridge.addr[`NB_ADDR_W-1:OFF_W] == OPT_BASE[`NB_ADDR_W-1:OFF_W])
		&& (offset <= off_t'(`NB_OPT_LAST));

	always_ff @(posedge clk_sys or negedge reset_l_main) begin
		if (!reset_l_main) begin
			options <= '{
				system_type: `NB_SYSTYPE_RST,
				snd_enable: `NB_SND_RST,
				ch_enable: `NB_CH_RST,
				dipsw: `NB_DIPSW_RST,
				default: '0
			};
			pchip_main <= 1'b0;
			pchip_sub <= 3'd0;
			for (int p = 0; p < `NB_PLAYERS; p++) begin
				pad_layout[p] <= LAYOUT_DEFAULT;
			end
		end else begin
			// one cycle behind the pchip registers
			options.cart_pchip <= pchip_encode(pchip_main, pchip_sub);
			if (bridge.wr && in_map) begin
				case (offset)
					off_t'('h00): pad_layout[0] <= pad_layout_e'(bridge.wr_data[3:0]);
					off_t'('h04): pad_layout[1] <= pad_layout_e'(bridge.wr_data[3:0]);
					off_t'('h08): options.dipsw <= bridge.wr_data[7:0];
					off_t'('h0C): options.system_type <= bridge.wr_data[1:0];
					off_t'('h10): options.memory_card_enable <= bridge.wr_data[1:0];
					off_t'('h14): options.use_mouse <= bridge.wr_data[1:0];
					off_t'('h18): options.video_mode <= bridge.wr_data[0];
					off_t'('h1C): options.ch_enable <= bridge.wr_data[5:0];
					off_t'('h20): options.snd_enable <= bridge.wr_data[3:0];
					off_t'('h24): pchip_main <= bridge.wr_data[0];
					off_t'('h28): options.use_pcm <= bridge.wr_data[0];
					off_t'('h2C): pchip_sub <= bridge.wr_data[2:0];
					off_t'('h30): options.cmc_chip <= bridge.wr_data[1:0];
					off_t'('h34): options.screen_x_pos <= bridge.wr_data[7:0];
					off_t'('h38): options.screen_y_pos <= bridge.wr_data[7:0];
					off_t'('h3C): options.v2_offset <= bridge.wr_data[23:0];
					off_t'('h40): options.cart_chip <= bridge.wr_data[1:0];
					default: ;
				endcase
			end
		end
	end

	// read-back, screen offsets are signed
	always_comb begin
		rd_mux = '0;
		case (offset)
			off_t'('h00): rd_mux = DW'(pad_layout[0]);
			off_t'('h04): rd_mux = DW'(pad_layout[1]);
			off_t'('h08): rd_mux = DW'(options.dipsw);
			off_t'('h0C): rd_mux = DW'(options.system_type);
			off_t'('h10): rd_mux = DW'(options.memory_card_enable);
			off_t'('h14): rd_mux = DW'(options.use_mouse);
			off_t'('h18): rd_mux = DW'(options.video_mode);
			off_t'('h1C): rd_mux = DW'(options.ch_enable);
			off_t'('h20): rd_mux = DW'(options.snd_enable);
			off_t'('h24): rd_mux = DW'(pchip_main);
			off_t'('h28): rd_mux = DW'(options.use_pcm);
			off_t'('h2C): rd_mux = DW'(pchip_sub);
			off_t'('h30): rd_mux = DW'(options.cmc_chip);
			off_t'('h34): rd_mux = DW'(signed'(options.screen_x_pos));
			off_t'('h38): rd_mux = DW'(signed'(options.screen_y_pos));
			off_t'('h3C): rd_mux = DW'(options.v2_offset);
			off_t'('h40): rd_mux = DW'(options.cart_chip);
			default: rd_mux = '0;
		endcase
	end

	// held until the next read strobe
	always_ff @(posedge clk_sys or negedge reset_l_main) begin
		if (!reset_l_main) begin
			bridge_rd_data <= '0;
		end else if (bridge.rd) begin
			bridge_rd_data <= in_map ? rd_mux : '0;
		end
	end

	// core waits for loading and a released L1
	always_ff @(posedge clk_sys or negedge reset_l_main) begin
		if (!reset_l_main) begin
			start_system <= 1'b0;
		end else begin
			start_system <= dataslot_allcomplete & core_run & ~p1_keys.l1;
		end
	end

	a_pchip_code_valid: assert property (@(posedge clk_sys) disable iff (!reset_l_main)
		options.cart_pchip != 4'd1)
		else $error("core_option_regs: cart_pchip took reserved code 1");

endmodule

// ==== hw/neo_bridge_config.svh ====
////////////////////////////////////////
// neo bridge configuration
// widths, addresses and reset values
////////////////////////////////////////

`ifndef NEO_BRIDGE_CONFIG_SVH
`define NEO_BRIDGE_CONFIG_SVH

// host bridge
`define NB_ADDR_W 32
`define NB_DATA_W 32

// remapped pads
`define NB_PLAYERS 2

// option register region
`define NB_OPT_BASE 32'hF000_0000
`define NB_OPT_LAST 'h40

// rom mask widths
`define NB_P2_W 23
`define NB_M_W 19
`define NB_V1_W 24
`define NB_CROM_W 24

// smallest c rom size step, 256 KiB
`define NB_CROM_BASE_LIMIT 'h4_0000

// option reset values
`define NB_DIPSW_RST 8'hFF
`define NB_SYSTYPE_RST 2'd1
`define NB_CH_RST 6'h3F
`define NB_SND_RST 4'hF

`endif

// ==== hw/neo_bridge_pkg.sv ====
////////////////////////////////////////
// neo bridge package
// bus, option, mask and pad types
////////////////////////////////////////

`include "neo_bridge_config.svh"

package neo_bridge_pkg;

	// one host cycle, rd and wr are one-cycle strobes
	typedef struct packed {
		logic wr;
		logic rd;
		logic [`NB_ADDR_W-1:0] addr;
		logic [`NB_DATA_W-1:0] wr_data;
	} bridge_req_t;

	typedef logic [`NB_P2_W-1:0] p2_mask_t;
	typedef logic [`NB_M_W-1:0] m_mask_t;
	typedef logic [`NB_V1_W-1:0] v1_mask_t;
	typedef logic [`NB_CROM_W-1:0] crom_mask_t;

	typedef struct packed {
		p2_mask_t p2;
		m_mask_t m;
		v1_mask_t v1;
		crom_mask_t crom;
	} rom_masks_t;

	typedef struct packed {
		logic [1:0] system_type;
		logic [1:0] memory_card_enable;
		logic [1:0] use_mouse;
		logic video_mode;
		logic [3:0] snd_enable;
		logic [5:0] ch_enable;
		logic [3:0] cart_pchip;
		logic use_pcm;
		logic [1:0] cart_chip;
		logic [1:0] cmc_chip;
		logic [7:0] dipsw;
		logic [7:0] screen_x_pos;
		logic [7:0] screen_y_pos;
		logic [23:0] v2_offset;
	} core_options_t;

	// pocket key bitmap, bit 0 is up
	typedef struct packed {
		logic start;
		logic select;
		logic r3;
		logic l3;
		logic r2;
		logic l2;
		logic r1;
		logic l1;
		logic y;
		logic x;
		logic b;
		logic a;
		logic right;
		logic left;
		logic down;
		logic up;
	} pad_keys_t;

	// neo geo joystick word, select on top
	typedef struct packed {
		logic select;
		logic start;
		logic d;
		logic c;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_bits_t;

	// any value not listed falls back to the default layout
	typedef enum logic [3:0] {
		LAYOUT_DEFAULT = 4'd0,
		LAYOUT_NEOGEO = 4'd1,
		LAYOUT_NEOGEO_CD = 4'd2
	} pad_layout_e;

endpackage

// ==== hw/neo_bridge_top.sv ====
////////////////////////////////////////
// neo_bridge_top
// host bridge options, rom masks and pads
////////////////////////////////////////

`timescale 1ns/1ps
`include "neo_bridge_config.svh"

module neo_bridge_top (
	input logic clk_sys,
	input logic reset_l_main,
	input neo_bridge_pkg::bridge_req_t bridge,
	input logic dataslot_allcomplete,
	input logic core_run,
	input neo_bridge_pkg::pad_keys_t pad_keys [`NB_PLAYERS],
	output logic [`NB_DATA_W-1:0] bridge_rd_data,
	output neo_bridge_pkg::core_options_t options,
	output neo_bridge_pkg::rom_masks_t rom_masks,
	output neo_bridge_pkg::joy_bits_t joystick [`NB_PLAYERS],
	output logic start_system
);

	import neo_bridge_pkg::*;

	// layout per player, from the option registers
	pad_layout_e pad_layout [`NB_PLAYERS];

	rom_mask_tracker u_rom_mask_tracker (
		.clk_sys(clk_sys),
		.reset_l_main(reset_l_main),
		.bridge(bridge),
		.rom_masks(rom_masks)
	);

	core_option_regs u_core_option_regs (
		.clk_sys(clk_sys),
		.reset_l_main(reset_l_main),
		.bridge(bridge),
		.dataslot_allcomplete(dataslot_allcomplete),
		.core_run(core_run),
		.p1_keys(pad_keys[0]),
		.options(options),
		.pad_layout(pad_layout),
		.bridge_rd_data(bridge_rd_data),
		.start_system(start_system)
	);

	pad_layout_remap u_pad_layout_remap (
		.clk_sys(clk_sys),
		.reset_l_main(reset_l_main),
		.pad_keys(pad_keys),
		.pad_layout(pad_layout),
		.joystick(joystick)
	);

endmodule

// ==== hw/pad_layout_remap.sv ====
////////////////////////////////////////
// pad_layout_remap
// pocket keys to neo geo joystick bits
////////////////////////////////////////

`timescale 1ns/1ps
`include "neo_bridge_config.svh"

module pad_layout_remap (
	input logic clk_sys,
	input logic reset_l_main,
	input neo_bridge_pkg::pad_keys_t pad_keys [`NB_PLAYERS],
	input neo_bridge_pkg::pad_layout_e pad_layout [`NB_PLAYERS],
	output neo_bridge_pkg::joy_bits_t joystick [`NB_PLAYERS]
);

	import neo_bridge_pkg::*;

	function automatic joy_bits_t remap(input pad_keys_t k, input pad_layout_e layout);
		joy_bits_t j;
		j.select = k.select;
		j.start = k.start;
		j.up = k.up;
		j.down = k.down;
		j.left = k.left;
		j.right = k.right;
		case (layout)
			// arcade stick order
			LAYOUT_NEOGEO: begin
				j.d = k.a;
				j.c = k.x;
				j.b = k.b;
				j.a = k.y;
			end
			LAYOUT_NEOGEO_CD: begin
				j.d = k.x;
				j.c = k.y;
				j.b = k.a;
				j.a = k.b;
			end
			// snes / xbox style pads
			default: begin
				j.d = k.y;
				j.c = k.x;
				j.b = k.b;
				j.a = k.a;
			end
		endcase
		return j;
	endfunction

	always_ff @(posedge clk_sys or negedge reset_l_main) begin
		if (!reset_l_main) begin
			for (int p = 0; p < `NB_PLAYERS; p++) begin
				joystick[p] <= '0;
			end
		end else begin
			for (int p = 0; p < `NB_PLAYERS; p++) begin
				joystick[p] <= remap(pad_keys[p], pad_layout[p]);
			end
		end
	end

endmodule

// ==== hw/rom_mask_tracker.sv ====
////////////////////////////////////////
// rom_mask_tracker
// derives P2, M, V1 and C ROM masks
// from host writes into the ROM windows
////////////////////////////////////////

`timescale 1ns/1ps
`include "neo_bridge_config.svh"

module rom_mask_tracker (
	input logic clk_sys,
	input logic reset_l_main,
	input neo_bridge_pkg::bridge_req_t bridge,
	output neo_bridge_pkg::rom_masks_t rom_masks
);

	import neo_bridge_pkg::*;

	localparam logic [`NB_ADDR_W-1:0] P2_BASE = 32'h1000_0000;
	localparam logic [`NB_ADDR_W-1:0] M_BASE = 32'h10F8_0000;
	localparam logic [`NB_ADDR_W-1:0] V1_BASE = 32'h2000_0000;
	localparam logic [`NB_ADDR_W-1:0] CROM_BASE = 32'h4000_0000;
	// covers 256 KiB << 7, the largest threshold
	localparam int CROM_ADDR_W = 26;
	localparam int THRESH_N = `NB_CROM_W - 16;
	// widest of the fill-down windows
	localparam int STAGE_W = `NB_V1_W;

	logic [STAGE_W-1:0] addr_q;
	logic p2_hit_q;
	logic m_hit_q;
	logic v1_hit_q;
	logic [CROM_ADDR_W-1:0] crom_addr;
	logic [THRESH_N-1:0] crom_above;
	logic [THRESH_N-1:0] crom_thresh;
	p2_mask_t p2_mask;
	m_mask_t m_mask;
	v1_mask_t v1_mask;
	crom_mask_t crom_mask;

	// stage 1, window hits
	always_ff @(posedge clk_sys or negedge reset_l_main) begin
		if (!reset_l_main) begin
			p2_hit_q <= 1'b0;
			m_hit_q <= 1'b0;
			v1_hit_q <= 1'b0;
		end else begin
			p2_hit_q <= bridge.wr && (bridge.addr[31:23] == P2_BASE[31:23]);
			m_hit_q <= bridge.wr && (bridge.addr[31:19] == M_BASE[31:19]);
			v1_hit_q <= bridge.wr && (bridge.addr[31:24] == V1_BASE[31:24]);
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= bridge.addr[STAGE_W-1:0];
	end

	// stage 2, fill-down masks
	span_mask #(.mask_t(p2_mask_t)) u_p2_mask (
		.clk_sys(clk_sys),
		.reset_l_main(reset_l_main),
		.hit(p2_hit_q),
		.addr(addr_q[`NB_P2_W-1:0]),
		.mask(p2_mask)
	);

	span_mask #(.mask_t(m_mask_t)) u_m_mask (
		.clk_sys(clk_sys),
		.reset_l_main(reset_l_main),
		.hit(m_hit_q),
		.addr(addr_q[`NB_M_W-1:0]),
		.mask(m_mask)
	);

	span_mask #(.mask_t(v1_mask_t)) u_v1_mask (
		.clk_sys(clk_sys),
		.reset_l_main(reset_l_main),
		.hit(v1_hit_q),
		.addr(addr_q[`NB_V1_W-1:0]),
		.mask(v1_mask)
	);

	// c rom size steps, bit k above 256 KiB << k
	always_comb begin
		for (int k = 0; k < THRESH_N; k++) begin
			crom_above[k] = crom_addr > (CROM_ADDR_W'(`NB_CROM_BASE_LIMIT) << k);
		end
	end

	// c rom runs 3 deep: last address, thresholds, mask
	always_ff @(posedge clk_sys or negedge reset_l_main) begin
		if (!reset_l_main) begin
			crom_addr <= '0;
			crom_thresh <= '0;
			crom_mask <= '0;
		end else begin
			if (bridge.wr && (bridge.addr[31:28] == CROM_BASE[31:28])) begin
				crom_addr <= bridge.addr[CROM_ADDR_W-1:0];
			end
			crom_thresh <= crom_above;
			crom_mask <= {crom_thresh, {(`NB_CROM_W - THRESH_N){|crom_thresh}}};
		end
	end

	assign rom_masks = '{p2: p2_mask, m: m_mask, v1: v1_mask, crom: crom_mask};

	a_no_rd_wr_overlap: assert property (@(posedge clk_sys) disable iff (!reset_l_main)
		!(bridge.rd && bridge.wr))
		else $error("rom_mask_tracker: rd and wr strobes high together");

endmodule

// ==== hw/span_mask.sv ====
////////////////////////////////////////
// span_mask
// registered fill-down mask of a ROM window
////////////////////////////////////////

`timescale 1ns/1ps

module span_mask #(
	parameter type mask_t = logic [7:0]
) (
	input logic clk_sys,
	input logic reset_l_main,
	input logic hit,
	input logic [$bits(mask_t)-1:0] addr,
	output mask_t mask
);

	mask_t fill;

	// bit i set when any address bit at or above i is set
	always_comb begin
		logic seen;
		seen = 1'b0;
		for (int i = $bits(mask_t) - 1; i >= 0; i--) begin
			seen = seen | addr[i];
			fill[i] = seen;
		end
	end

	always_ff @(posedge clk_sys or negedge reset_l_main) begin
		if (!reset_l_main) begin
			mask <= '0;
		end else if (hit) begin
			mask <= fill;
		end
	end

	// mask stays a solid run of ones from bit 0
	a_mask_contiguous: assert property (@(posedge clk_sys) disable iff (!reset_l_main)
		((mask & (mask + 1'b1)) == '0))
		else $error("span_mask: mask %h is not contiguous", mask);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the neo bridge testbench with Verilator.
set -u

cd "$(dirname "$0")"

LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'

verilator --binary --timing -Wno-fatal -f files.f \
	--top-module tb_neo_bridge -o tb_neo_bridge
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_neo_bridge > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "$FAIL_MSG" "$LOG"; then
	exit 1
fi
if ! grep -qF '*** TEST PASSED ***' "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// ==== verif/neo_bridge_checker.sv ====
////////////////////////////////////////
// neo_bridge_checker
// compares DUT ports with expected values
////////////////////////////////////////

`timescale 1ns/1ps
`include "neo_bridge_config.svh"

module neo_bridge_checker (
	input logic clk_sys,
	input logic chk_valid,
	input logic [4:0] chk_port,
	input logic [31:0] chk_exp,
	input logic [3:0] chk_delay,
	input logic [`NB_DATA_W-1:0] bridge_rd_data,
	input neo_bridge_pkg::core_options_t options,
	input neo_bridge_pkg::rom_masks_t rom_masks,
	input neo_bridge_pkg::joy_bits_t joystick [`NB_PLAYERS],
	input logic start_system,
	output int err_count,
	output int check_count
);

	import neo_bridge_pkg::*;

	// port codes shared with the testbench table
	localparam logic [4:0] PORT_RD = 5'd1;
	localparam logic [4:0] PORT_DIPSW = 5'd2;
	localparam logic [4:0] PORT_SYSTYPE = 5'd3;
	localparam logic [4:0] PORT_CH = 5'd4;
	localparam logic [4:0] PORT_SND = 5'd5;
	localparam logic [4:0] PORT_PCHIP = 5'd6;
	localparam logic [4:0] PORT_P2 = 5'd7;
	localparam logic [4:0] PORT_M = 5'd8;
	localparam logic [4:0] PORT_V1 = 5'd9;
	localparam logic [4:0] PORT_CROM = 5'd10;
	localparam logic [4:0] PORT_JOY0 = 5'd11;
	localparam logic [4:0] PORT_JOY1 = 5'd12;
	localparam logic [4:0] PORT_START = 5'd13;
	localparam logic [4:0] PORT_MEMCARD = 5'd14;
	localparam logic [4:0] PORT_MOUSE = 5'd15;
	localparam logic [4:0] PORT_VIDEO = 5'd16;
	localparam logic [4:0] PORT_PCM = 5'd17;
	localparam logic [4:0] PORT_CMC = 5'd18;
	localparam logic [4:0] PORT_SCRX = 5'd19;
	localparam logic [4:0] PORT_SCRY = 5'd20;
	localparam logic [4:0] PORT_V2 = 5'd21;
	localparam logic [4:0] PORT_CART = 5'd22;

	initial begin
		err_count = 0;
		check_count = 0;
	end

	function automatic string port_name(input logic [4:0] port);
		case (port)
			PORT_RD: return "bridge_rd_data";
			PORT_DIPSW: return "options.dipsw";
			PORT_SYSTYPE: return "options.system_type";
			PORT_CH: return "options.ch_enable";
			PORT_SND: return "options.snd_enable";
			PORT_PCHIP: return "options.cart_pchip";
			PORT_P2: return "rom_masks.p2";
			PORT_M: return "rom_masks.m";
			PORT_V1: return "rom_masks.v1";
			PORT_CROM: return "rom_masks.crom";
			PORT_JOY0: return "joystick[0]";
			PORT_JOY1: return "joystick[1]";
			PORT_START: return "start_system";
			PORT_MEMCARD: return "options.memory_card_enable";
			PORT_MOUSE: return "options.use_mouse";
			PORT_VIDEO: return "options.video_mode";
			PORT_PCM: return "options.use_pcm";
			PORT_CMC: return "options.cmc_chip";
			PORT_SCRX: return "options.screen_x_pos";
			PORT_SCRY: return "options.screen_y_pos";
			PORT_V2: return "options.v2_offset";
			PORT_CART: return "options.cart_chip";
			default: return "unknown";
		endcase
	endfunction

	always begin
		logic [4:0] port;
		logic [31:0] exp_val;
		logic [31:0] act;
		logic known;
		int n;
		@(posedge clk_sys);
		if (chk_valid) begin
			port = chk_port;
			exp_val = chk_exp;
			n = int'(chk_delay);
			repeat (n - 1) @(posedge clk_sys);
			// sample away from the clock edge
			@(negedge clk_sys);
			known = 1'b1;
			case (port)
				PORT_RD: act = bridge_rd_data;
				PORT_DIPSW: act = 32'(options.dipsw);
				PORT_SYSTYPE: act = 32'(options.system_type);
				PORT_CH: act = 32'(options.ch_enable);
				PORT_SND: act = 32'(options.snd_enable);
				PORT_PCHIP: act = 32'(options.cart_pchip);
				PORT_P2: act = 32'(rom_masks.p2);
				PORT_M: act = 32'(rom_masks.m);
				PORT_V1: act = 32'(rom_masks.v1);
				PORT_CROM: act = 32'(rom_masks.crom);
				PORT_JOY0: act = 32'(joystick[0]);
				PORT_JOY1: act = 32'(joystick[1]);
				PORT_START: act = 32'(start_system);
				PORT_MEMCARD: act = 32'(options.memory_card_enable);
				PORT_MOUSE: act = 32'(options.use_mouse);
				PORT_VIDEO: act = 32'(options.video_mode);
				PORT_PCM: act = 32'(options.use_pcm);
				PORT_CMC: act = 32'(options.cmc_chip);
				PORT_SCRX: act = 32'(options.screen_x_pos);
				PORT_SCRY: act = 32'(options.screen_y_pos);
				PORT_V2: act = 32'(options.v2_offset);
				PORT_CART: act = 32'(options.cart_chip);
				default: begin
					known = 1'b0;
					act = '0;
				end
			endcase
			check_count = check_count + 1;
			if (!known) begin
				err_count = err_count + 1;
				$display("check asked for unknown port code %0d at %0t", port, $time);
			end else if (act !== exp_val) begin
				err_count = err_count + 1;
				$display("FAIL %s expected %h actual %h at %0t", port_name(port),
					exp_val, act, $time);
			end
		end
	end

endmodule

// ==== verif/tb_neo_bridge.sv ====
////////////////////////////////////////
// tb_neo_bridge
// table driven testbench of the neo bridge
////////////////////////////////////////

`timescale 1ns/1ps
`include "neo_bridge_config.svh"

module tb_neo_bridge;

	import neo_bridge_pkg::*;

	localparam logic [2:0] OP_IDLE = 3'd0;
	localparam logic [2:0] OP_WRITE = 3'd1;
	localparam logic [2:0] OP_READ = 3'd2;
	localparam logic [2:0] OP_PAD = 3'd3;
	localparam logic [2:0] OP_START = 3'd4;

	localparam logic [4:0] PORT_NONE = 5'd0;
	localparam logic [4:0] PORT_RD = 5'd1;
	localparam logic [4:0] PORT_DIPSW = 5'd2;
	localparam logic [4:0] PORT_SYSTYPE = 5'd3;
	localparam logic [4:0] PORT_CH = 5'd4;
	localparam logic [4:0] PORT_SND = 5'd5;
	localparam logic [4:0] PORT_PCHIP = 5'd6;
	localparam logic [4:0] PORT_P2 = 5'd7;
	localparam logic [4:0] PORT_M = 5'd8;
	localparam logic [4:0] PORT_V1 = 5'd9;
	localparam logic [4:0] PORT_CROM = 5'd10;
	localparam logic [4:0] PORT_JOY0 = 5'd11;
	localparam logic [4:0] PORT_JOY1 = 5'd12;
	localparam logic [4:0] PORT_START = 5'd13;
	localparam logic [4:0] PORT_MEMCARD = 5'd14;
	localparam logic [4:0] PORT_MOUSE = 5'd15;
	localparam logic [4:0] PORT_VIDEO = 5'd16;
	localparam logic [4:0] PORT_PCM = 5'd17;
	localparam logic [4:0] PORT_CMC = 5'd18;
	localparam logic [4:0] PORT_SCRX = 5'd19;
	localparam logic [4:0] PORT_SCRY = 5'd20;
	localparam logic [4:0] PORT_V2 = 5'd21;
	localparam logic [4:0] PORT_CART = 5'd22;

	typedef struct packed {
		logic [2:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [4:0] port;
		logic [31:0] exp_val;
		logic [3:0] delay;
	} entry_t;

	logic clk_sys;
	logic reset_l_main;
	bridge_req_t bridge;
	logic dataslot_allcomplete;
	logic core_run;
	pad_keys_t pad_keys [`NB_PLAYERS];
	logic [`NB_DATA_W-1:0] bridge_rd_data;
	core_options_t options;
	rom_masks_t rom_masks;
	joy_bits_t joystick [`NB_PLAYERS];
	logic start_system;

	logic chk_valid;
	logic [4:0] chk_port;
	logic [31:0] chk_exp;
	logic [3:0] chk_delay;
	int err_count;
	int check_count;

	entry_t tbl [$];
	logic built;

	neo_bridge_top UUT (
		.clk_sys(clk_sys),
		.reset_l_main(reset_l_main),
		.bridge(bridge),
		.dataslot_allcomplete(dataslot_allcomplete),
		.core_run(core_run),
		.pad_keys(pad_keys),
		.bridge_rd_data(bridge_rd_data),
		.options(options),
		.rom_masks(rom_masks),
		.joystick(joystick),
		.start_system(start_system)
	);

	neo_bridge_checker u_checker (
		.clk_sys(clk_sys),
		.chk_valid(chk_valid),
		.chk_port(chk_port),
		.chk_exp(chk_exp),
		.chk_delay(chk_delay),
		.bridge_rd_data(bridge_rd_data),
		.options(options),
		.rom_masks(rom_masks),
		.joystick(joystick),
		.start_system(start_system),
		.err_count(err_count),
		.check_count(check_count)
	);

	always #50 clk_sys = ~clk_sys;

	task automatic add(input logic [2:0] op, input logic [31:0] addr, input logic [31:0] data,
		input logic [4:0] port, input logic [31:0] exp_val, input int delay);
		entry_t e;
		e = '{op, addr, data, port, exp_val, 4'(delay)};
		tbl.push_back(e);
	endtask

	// register width per option offset
	function automatic int opt_width(input int off);
		int widths [17];
		widths = '{4, 4, 8, 2, 2, 2, 1, 6, 4, 1, 1, 3, 2, 8, 8, 24, 2};
		return widths[off / 4];
	endfunction

	// option output field behind each offset
	function automatic logic [4:0] opt_port(input int off);
		logic [4:0] ports [17];
		ports = '{PORT_NONE, PORT_NONE, PORT_DIPSW, PORT_SYSTYPE, PORT_MEMCARD, PORT_MOUSE,
			PORT_VIDEO, PORT_CH, PORT_SND, PORT_NONE, PORT_PCM, PORT_NONE, PORT_CMC,
			PORT_SCRX, PORT_SCRY, PORT_V2, PORT_CART};
		return ports[off / 4];
	endfunction

	function automatic logic [31:0] readback(input int off, input logic [31:0] d);
		logic [31:0] keep;
		logic [31:0] v;
		int w;
		w = opt_width(off);
		keep = (32'd1 << w) - 32'd1;
		v = d & keep;
		if ((off == 'h34 || off == 'h38) && v[w-1]) begin
			v = v | ~keep;
		end
		return v;
	endfunction

	// all ones up to the highest set address bit
	function automatic logic [31:0] fill_mask(input logic [31:0] a, input int w);
		logic [31:0] m;
		m = 32'd0;
		for (int b = 0; b < w; b++) begin
			if ((a & ~((32'd1 << b) - 32'd1) & ((32'd1 << w) - 32'd1)) != 32'd0) begin
				m[b] = 1'b1;
			end
		end
		return m;
	endfunction

	function automatic logic [31:0] crom_expect(input logic [31:0] off);
		logic [7:0] t;
		for (int k = 0; k < 8; k++) begin
			t[k] = off[25:0] > (26'h4_0000 << k);
		end
		return {8'd0, t, {16{|t}}};
	endfunction

	function automatic logic [31:0] pchip_expect(input logic main, input logic [2:0] sub);
		if (main) begin
			return 32'd2;
		end
		case (sub)
			3'd1, 3'd2, 3'd3, 3'd4, 3'd5: return 32'(sub) + 32'd2;
			default: return 32'd0;
		endcase
	endfunction

	// joystick word from the layout table
	function automatic logic [31:0] joy_expect(input logic [15:0] k, input int layout);
		logic [3:0] dcba;
		case (layout)
			1: dcba = {k[4], k[6], k[5], k[7]};
			2: dcba = {k[6], k[7], k[4], k[5]};
			default: dcba = {k[7], k[6], k[5], k[4]};
		endcase
		return {22'd0, k[14], k[15], dcba, k[0], k[1], k[2], k[3]};
	endfunction

	task automatic build_table();
		logic [31:0] d;
		logic [31:0] keep;
		logic [31:0] keys;
		logic [2:0] main_sub [8];
		logic [31:0] p2_off [3];
		logic [31:0] crom_off [4];
		int layouts [4];
		// reset values
		add(OP_IDLE, 0, 0, PORT_DIPSW, 32'hFF, 1);
		add(OP_IDLE, 0, 0, PORT_SYSTYPE, 32'd1, 1);
		add(OP_IDLE, 0, 0, PORT_CH, 32'h3F, 1);
		add(OP_IDLE, 0, 0, PORT_SND, 32'hF, 1);
		add(OP_IDLE, 0, 0, PORT_PCHIP, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_MEMCARD, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_MOUSE, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_VIDEO, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_PCM, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_CMC, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_SCRX, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_SCRY, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_V2, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_CART, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_P2, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_M, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_V1, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_CROM, 32'd0, 1);
		add(OP_IDLE, 0, 0, PORT_START, 32'd0, 1);
		// option write and read-back
		for (int off = 0; off <= 'h40; off += 4) begin
			d = $urandom();
			keep = (32'd1 << opt_width(off)) - 32'd1;
			add(OP_WRITE, 32'hF000_0000 + off, d, opt_port(off), d & keep, 1);
			add(OP_READ, 32'hF000_0000 + off, 0, PORT_RD, readback(off, d), 1);
		end
		add(OP_READ, 32'hF000_0044, 0, PORT_RD, 32'd0, 1);
		add(OP_READ, 32'hF000_0100, 0, PORT_RD, 32'd0, 1);
		// sub chip codes, main set on steps 0 and 6
		main_sub = '{3'd3, 3'd0, 3'd1, 3'd5, 3'd6, 3'd7, 3'd0, 3'd3};
		for (int i = 0; i < 8; i++) begin
			add(OP_WRITE, 32'hF000_0024, 32'(i == 0 || i == 6), PORT_NONE, 0, 0);
			add(OP_WRITE, 32'hF000_002C, 32'(main_sub[i]), PORT_PCHIP,
				pchip_expect(i == 0 || i == 6, main_sub[i]), 2);
		end
		// rom masks
		p2_off = '{32'h1234, 32'h7F_FFFF, 32'h40_0000};
		foreach (p2_off[i]) begin
			add(OP_WRITE, 32'h1000_0000 + p2_off[i], 0, PORT_P2, fill_mask(p2_off[i], 23), 2);
		end
		add(OP_WRITE, 32'h10F8_0100, 0, PORT_M, fill_mask(32'h100, 19), 2);
		add(OP_WRITE, 32'h10FF_0001, 0, PORT_M, fill_mask(32'h7_0001, 19), 2);
		add(OP_WRITE, 32'h2012_3456, 0, PORT_V1, fill_mask(32'h12_3456, 24), 2);
		add(OP_WRITE, 32'h20FF_FFFF, 0, PORT_V1, fill_mask(32'hFF_FFFF, 24), 2);
		crom_off = '{32'h4_0001, 32'h100_0000, 32'h3FF_FFFF, 32'h3_FFFF};
		foreach (crom_off[i]) begin
			add(OP_WRITE, 32'h4000_0000 + crom_off[i], 0, PORT_CROM,
				crom_expect(crom_off[i]), 3);
		end
		// back to back writes into different windows
		add(OP_WRITE, 32'h1000_0100, 0, PORT_NONE, 0, 0);
		add(OP_WRITE, 32'h10F8_0001, 0, PORT_NONE, 0, 0);
		add(OP_WRITE, 32'h2000_8000, 0, PORT_NONE, 0, 0);
		add(OP_WRITE, 32'h4020_0000, 0, PORT_CROM, crom_expect(32'h20_0000), 3);
		add(OP_IDLE, 0, 0, PORT_P2, fill_mask(32'h100, 23), 1);
		add(OP_IDLE, 0, 0, PORT_M, fill_mask(32'h1, 19), 1);
		add(OP_IDLE, 0, 0, PORT_V1, fill_mask(32'h8000, 24), 1);
		// button layouts
		layouts = '{0, 1, 2, 7};
		foreach (layouts[i]) begin
			add(OP_WRITE, 32'hF000_0000, 32'(layouts[i]), PORT_NONE, 0, 0);
			add(OP_WRITE, 32'hF000_0004, 32'(layouts[i]), PORT_NONE, 0, 0);
			for (int r = 0; r < 3; r++) begin
				keys = $urandom();
				add(OP_PAD, 0, keys, PORT_JOY0, joy_expect(keys[15:0], layouts[i]), 1);
				add(OP_IDLE, 0, 0, PORT_JOY1, joy_expect(keys[31:16], layouts[i]), 1);
			end
		end
		// start gate data bits are l1, core_run and allcomplete
		for (int s = 0; s < 8; s++) begin
			add(OP_START, 0, 32'(s), PORT_START, 32'(s[0] & s[1] & ~s[2]), 1);
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		reset_l_main = 1'b0;
		bridge = '0;
		dataslot_allcomplete = 1'b0;
		core_run = 1'b0;
		for (int p = 0; p < `NB_PLAYERS; p++) begin
			pad_keys[p] = '0;
		end
		chk_valid = 1'b0;
		chk_port = PORT_NONE;
		chk_exp = '0;
		chk_delay = '0;
		built = 1'b0;
		void'($urandom(32'hb72c3e57));
		build_table();
		built = 1'b1;
		repeat (16) @(posedge clk_sys);
		reset_l_main <= 1'b1;
		foreach (tbl[i]) begin
			@(posedge clk_sys);
			bridge.wr <= 1'b0;
			bridge.rd <= 1'b0;
			chk_valid <= 1'b0;
			case (tbl[i].op)
				OP_WRITE: begin
					bridge.wr <= 1'b1;
					bridge.addr <= tbl[i].addr;
					bridge.wr_data <= tbl[i].data;
				end
				OP_READ: begin
					bridge.rd <= 1'b1;
					bridge.addr <= tbl[i].addr;
				end
				OP_PAD: begin
					pad_keys[0] <= tbl[i].data[15:0];
					pad_keys[1] <= tbl[i].data[31:16];
				end
				OP_START: begin
					dataslot_allcomplete <= tbl[i].data[0];
					core_run <= tbl[i].data[1];
					pad_keys[0].l1 <= tbl[i].data[2];
				end
				default: ;
			endcase
			if (tbl[i].port != PORT_NONE) begin
				chk_valid <= 1'b1;
				chk_port <= tbl[i].port;
				chk_exp <= tbl[i].exp_val;
				chk_delay <= tbl[i].delay;
			end
			if (tbl[i].delay != 0) begin
				@(posedge clk_sys);
				bridge.wr <= 1'b0;
				bridge.rd <= 1'b0;
				chk_valid <= 1'b0;
				repeat (tbl[i].delay) @(posedge clk_sys);
			end
		end
		@(posedge clk_sys);
		bridge.wr <= 1'b0;
		bridge.rd <= 1'b0;
		chk_valid <= 1'b0;
		repeat (4) @(posedge clk_sys);
		$display("checks: %0d errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// run limit scales with the table length
	initial begin
		wait (built);
		repeat (tbl.size() * 8 + 100) @(posedge clk_sys);
		$display("timeout: the stimulus table did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
